// ==== Makefile ====
TOP := tb_debug_top

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing -Wno-fatal -f sim.f --top-module $(TOP) \
		-Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== core_dbg_if.sv ====
`timescale 1ns/1ns

interface core_dbg_if;
    import debug_pkg::*;

    logic       halt;        // core frozen while high
    logic       restart;     // one cycle pulse, pc back to 0
    reg_addr_t  reg_rd_addr; // register picked for the dump
    word_t      reg_rd_data; // comb read of that register
    inst_addr_t pc;
    logic       program_end; // word at pc is the end marker

    modport ctrl (
        output halt,
        output restart,
        output reg_rd_addr,
        input  reg_rd_data,
        input  pc,
        input  program_end
    );

    modport core (
        input  halt,
        input  restart,
        input  reg_rd_addr,
        output reg_rd_data,
        output pc,
        output program_end
    );

endinterface

// ==== debug_ctrl.sv ====
`timescale 1ns/1ns

module debug_ctrl (
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                i_rx_valid,
    input  debug_pkg::word_t    i_rx_data,
    core_dbg_if.ctrl            dbg,
    output logic                o_mem_wr_en,
    output debug_pkg::inst_addr_t o_mem_wr_addr,
    output debug_pkg::word_t    o_mem_wr_data,
    output logic                o_push,
    output debug_pkg::word_t    o_push_data,
    input  logic                i_fifo_full,
    output logic                o_busy
);
    import debug_pkg::*;

    dbg_state_t state;
    inst_addr_t load_addr;   // next memory slot to fill
    word_t      wr_data_q;   // captured program word
    logic       wr_en_q;
    logic       prog_ready;  // a complete program sits in memory
    logic       step_mode;   // dump returns to step wait instead of idle
    logic       restart_q;
    logic [$clog2(DUMP_WORDS)-1:0] dump_idx;

    logic dump_last;
    logic push_ok;

    // halt only drops while running or for the single step cycle
    assign dbg.halt    = !(state == S_CONT_RUN || state == S_STEP_EXEC);
    assign dbg.restart = restart_q;

    // dump reads the register file through the core
    assign dbg.reg_rd_addr = reg_addr_t'(dump_idx[2:0]);

    assign push_ok     = (state == S_DUMP) && !i_fifo_full;
    assign dump_last   = (dump_idx == DUMP_WORDS - 1);
    assign o_push      = push_ok;
    assign o_push_data = (dump_idx < NUM_REGS) ? dbg.reg_rd_data
                                               : word_t'(dbg.pc); // pc zero extended

    assign o_mem_wr_en   = wr_en_q;
    assign o_mem_wr_addr = load_addr;
    assign o_mem_wr_data = wr_data_q;

    assign o_busy = (state != S_IDLE);

    // program word latch
    always_ff @(posedge i_clk) begin
        if (state == S_LOAD_WAIT && i_rx_valid)
            wr_data_q <= i_rx_data;
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state      <= S_IDLE;
            load_addr  <= '0;
            wr_en_q    <= 1'b0;
            prog_ready <= 1'b0;
            step_mode  <= 1'b0;
            restart_q  <= 1'b0;
            dump_idx   <= '0;
        end else begin
            restart_q <= 1'b0; // pulses by default
            wr_en_q   <= 1'b0;

            case (state)
                S_IDLE: begin
                    if (i_rx_valid) begin
                        if (i_rx_data == CMD_LOAD) begin
                            prog_ready <= 1'b0; // old program no longer trusted
                            load_addr  <= '0;
                            state      <= S_LOAD_WAIT;
                        end else if (i_rx_data == CMD_CONT && prog_ready) begin
                            step_mode <= 1'b0;
                            state     <= S_CONT_RUN;
                        end else if (i_rx_data == CMD_STEP && prog_ready) begin
                            step_mode <= 1'b1;
                            state     <= S_STEP_WAIT;
                        end
                        // anything else is dropped
                    end
                end

                S_LOAD_WAIT: begin
                    if (i_rx_valid) begin
                        wr_en_q <= 1'b1; // write lands one cycle after valid
                        state   <= S_LOAD_WRITE;
                    end
                end

                S_LOAD_WRITE: begin
                    // memory takes the word on this edge
                    if (load_addr == inst_addr_t'(IMEM_DEPTH - 1))
                        load_addr <= '0;
                    else
                        load_addr <= load_addr + 1'b1;

                    if (wr_data_q == END_INSTR) begin
                        prog_ready <= 1'b1;
                        restart_q  <= 1'b1; // core starts fresh at pc 0
                        state      <= S_IDLE;
                    end else begin
                        state <= S_LOAD_WAIT;
                    end
                end

                S_CONT_RUN: begin
                    if (dbg.program_end) begin
                        dump_idx <= '0;
                        state    <= S_DUMP;
                    end
                end

                S_STEP_WAIT: begin
                    if (i_rx_valid) begin
                        if (i_rx_data == CMD_NEXT) begin
                            state <= S_STEP_EXEC;
                        end else if (i_rx_data == CMD_CANCEL) begin
                            step_mode <= 1'b0;
                            restart_q <= 1'b1;
                            state     <= S_IDLE;
                        end
                    end
                end

                S_STEP_EXEC: begin
                    // exactly one instruction retired on this edge
                    dump_idx <= '0;
                    state    <= S_DUMP;
                end

                S_DUMP: begin
                    if (push_ok) begin
                        dump_idx <= dump_idx + 1'b1;
                        if (dump_last) begin
                            dump_idx <= '0;
                            if (step_mode) begin
                                state <= S_STEP_WAIT;
                            end else begin
                                restart_q <= 1'b1; // rerun would start at pc 0
                                state     <= S_IDLE;
                            end
                        end
                    end
                    // full fifo just stalls the index
                end

                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// ==== debug_pkg.sv ====
package debug_pkg;

    // widths with a meaning
    typedef logic [31:0] word_t;      // data or instruction word
    typedef logic [2:0]  reg_addr_t;  // register file index
    typedef logic [5:0]  inst_addr_t; // instruction memory word address

    // sizes
    localparam int NUM_REGS    = 8;
    localparam int IMEM_DEPTH  = 64;
    localparam int DUMP_WORDS  = 9;  // r0..r7 then pc
    localparam int FIFO_DEPTH  = 4;
    localparam int CREDIT_INIT = 2;  // credits held after reset

    // host command words, ascii packed
    localparam word_t CMD_LOAD   = "\0lom";
    localparam word_t CMD_CONT   = "\0com";
    localparam word_t CMD_STEP   = "\0stm";
    localparam word_t CMD_NEXT   = "nxst";
    localparam word_t CMD_CANCEL = "clst";

    localparam word_t END_INSTR = 32'hffff_ffff; // program end marker

    // opcodes live in bits 31:28
    localparam logic [3:0] OP_ADDI = 4'h1;
    localparam logic [3:0] OP_ADD  = 4'h2;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD_WAIT,   // waiting for next program word
        S_LOAD_WRITE,  // memory write in flight
        S_CONT_RUN,    // free running until end marker
        S_STEP_WAIT,   // step mode, waiting for next/cancel
        S_STEP_EXEC,   // one cycle with halt released
        S_DUMP         // streaming state words into the fifo
    } dbg_state_t;

endpackage

// ==== debug_top.sv ====
`timescale 1ns/1ns

module debug_top (
    input  logic             i_clk,
    input  logic             i_reset,
    input  logic             i_rx_valid,
    input  debug_pkg::word_t i_rx_data,
    input  logic             i_tx_credit,
    output logic             o_tx_valid,
    output debug_pkg::word_t o_tx_data,
    output logic             o_halted,
    output logic             o_busy
);
    import debug_pkg::*;

    core_dbg_if dbg_if ();

    logic       mem_wr_en;
    inst_addr_t mem_wr_addr;
    word_t      mem_wr_data;
    inst_addr_t fetch_addr;
    word_t      fetch_data;
    logic       push;
    word_t      push_data;
    logic       fifo_full;

    assign o_halted = dbg_if.halt;

    debug_ctrl u_ctrl (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_rx_valid   (i_rx_valid),
        .i_rx_data    (i_rx_data),
        .dbg          (dbg_if.ctrl),
        .o_mem_wr_en  (mem_wr_en),
        .o_mem_wr_addr(mem_wr_addr),
        .o_mem_wr_data(mem_wr_data),
        .o_push       (push),
        .o_push_data  (push_data),
        .i_fifo_full  (fifo_full),
        .o_busy       (o_busy)
    );

    prog_mem u_mem (
        .i_clk    (i_clk),
        .i_wr_en  (mem_wr_en),
        .i_wr_addr(mem_wr_addr),
        .i_wr_data(mem_wr_data),
        .i_rd_addr(fetch_addr),
        .o_rd_data(fetch_data)
    );

    mini_core u_core (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .dbg         (dbg_if.core),
        .o_fetch_addr(fetch_addr),
        .i_fetch_data(fetch_data)
    );

    tx_credit_fifo u_fifo (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_push     (push),
        .i_push_data(push_data),
        .o_full     (fifo_full),
        .i_credit   (i_tx_credit),
        .o_tx_valid (o_tx_valid),
        .o_tx_data  (o_tx_data)
    );

endmodule

// ==== mini_core.sv ====
`timescale 1ns/1ns

module mini_core (
    input  logic                  i_clk,
    input  logic                  i_reset,
    core_dbg_if.core              dbg,
    output debug_pkg::inst_addr_t o_fetch_addr,
    input  debug_pkg::word_t      i_fetch_data
);
    import debug_pkg::*;

    inst_addr_t pc;
    word_t      regs [NUM_REGS];

    // instruction fields
    logic [3:0] op;
    reg_addr_t  rd;
    reg_addr_t  rs;
    reg_addr_t  rt;
    word_t      imm_ext;

    logic  at_end;
    logic  retire;   // an instruction completes this cycle
    word_t result;
    logic  wr_en;

    assign op      = i_fetch_data[31:28];
    assign rd      = i_fetch_data[27:25];
    assign rs      = i_fetch_data[24:22];
    assign rt      = i_fetch_data[21:19];
    assign imm_ext = {{16{i_fetch_data[15]}}, i_fetch_data[15:0]}; // sign extend

    assign at_end = (i_fetch_data == END_INSTR);
    assign retire = !dbg.halt && !at_end;

    always_comb begin
        result = '0;
        wr_en  = 1'b0;
        case (op)
            OP_ADDI: begin
                result = regs[rs] + imm_ext;
                wr_en  = 1'b1;
            end
            OP_ADD: begin
                result = regs[rs] + regs[rt];
                wr_en  = 1'b1;
            end
            default: ; // unknown opcode is a nop
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            pc <= '0;
        end else if (dbg.restart) begin
            pc <= '0;            // registers keep their values
        end else if (retire) begin
            pc <= pc + 1'b1;     // pc freezes at the end marker
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end else if (retire && wr_en) begin
            regs[rd] <= result;  // r0 is an ordinary register here
        end
    end

    assign o_fetch_addr    = pc;
    assign dbg.pc          = pc;
    assign dbg.program_end = at_end;
    assign dbg.reg_rd_data = regs[dbg.reg_rd_addr]; // debug read port

endmodule

// ==== prog_mem.sv ====
`timescale 1ns/1ns

module prog_mem (
    input  logic                  i_clk,
    input  logic                  i_wr_en,
    input  debug_pkg::inst_addr_t i_wr_addr,
    input  debug_pkg::word_t      i_wr_data,
    input  debug_pkg::inst_addr_t i_rd_addr,
    output debug_pkg::word_t      o_rd_data
);
    import debug_pkg::*;

    word_t mem [IMEM_DEPTH]; // contents survive across runs

    always_ff @(posedge i_clk) begin
        if (i_wr_en)
            mem[i_wr_addr] <= i_wr_data;
    end

    // fetch path, no clock
    assign o_rd_data = mem[i_rd_addr];

endmodule

// ==== sim.f ====
debug_pkg.sv
core_dbg_if.sv
debug_ctrl.sv
prog_mem.sv
mini_core.sv
tx_credit_fifo.sv
debug_top.sv
tb_debug_top.sv

// ==== tb_debug_top.sv ====
`timescale 1ns/1ns

module tb_debug_top;
    import debug_pkg::*;

    localparam logic [31:0] SEED = 32'h79fe6c3a;
    localparam int NUM_PROGS = 3;
    localparam int MAX_LEN   = 8;  // longest random program, end marker not counted
    // every dump waits on sparse credits, every host word takes 4 cycles
    localparam int CYCLE_LIMIT = 2 * NUM_PROGS * ((MAX_LEN + 4) * (DUMP_WORDS * 8 + 60)
                                 + (2 * MAX_LEN + 8) * 4) + 500;

    logic  i_clk;
    logic  i_reset;
    logic  i_rx_valid;
    word_t i_rx_data;
    logic  i_tx_credit;
    logic  o_tx_valid;
    word_t o_tx_data;
    logic  o_halted;
    logic  o_busy;

    word_t mem_model [IMEM_DEPTH]; // what the host has written so far
    word_t base_regs [NUM_REGS];   // register file at the start of the next run
    word_t exp_q [$];              // dump words still to arrive

    int errors;
    int checks;
    int sent_count;   // words seen on o_tx_valid
    int granted;      // credit pulses driven
    int gap;          // cycles until the next credit
    int cycles;
    logic credit_on;
    logic [31:0] prog_rng;
    logic [31:0] credit_rng;

    debug_top UUT (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_rx_valid (i_rx_valid),
        .i_rx_data  (i_rx_data),
        .i_tx_credit(i_tx_credit),
        .o_tx_valid (o_tx_valid),
        .o_tx_data  (o_tx_data),
        .o_halted   (o_halted),
        .o_busy     (o_busy)
    );

    always #10 i_clk = ~i_clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // dump word idx after a given number of retired instructions from pc 0
    function automatic word_t ref_dump_word(input int retired, input int idx);
        word_t r [NUM_REGS];
        word_t ins;
        word_t imm;
        int    pc;
        int    n;
        r  = base_regs;
        pc = 0;
        n  = 0;
        while (n < retired && mem_model[pc] != END_INSTR) begin
            ins = mem_model[pc];
            imm = {{16{ins[15]}}, ins[15:0]};
            case (ins[31:28])
                OP_ADDI: r[ins[27:25]] = r[ins[24:22]] + imm;
                OP_ADD:  r[ins[27:25]] = r[ins[24:22]] + r[ins[21:19]];
                default: ;
            endcase
            pc = (pc + 1) % IMEM_DEPTH;
            n++;
        end
        if (idx < NUM_REGS)
            return r[idx];
        return word_t'(pc); // last word is the pc
    endfunction

    task automatic check_word(input word_t got, input word_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_credit(input int sent, input int allowed);
        checks++;
        if (sent > allowed) begin
            errors++;
            $display("[ERROR] %0t %0d words sent with only %0d credits", $time, sent, allowed);
        end
    endtask

    // monitor and host credit return share one process
    always @(negedge i_clk) begin
        if (!i_reset && o_tx_valid) begin
            sent_count++;
            check_credit(sent_count, CREDIT_INIT + granted);
            if (exp_q.size() == 0) begin
                errors++;
                $display("[ERROR] %0t unexpected dump word %h", $time, o_tx_data);
            end else begin
                check_word(o_tx_data, exp_q.pop_front(), "dump word");
            end
        end
        i_tx_credit = 1'b0;
        // random gaps, never more than 4 credits outstanding
        if (!i_reset && credit_on && (CREDIT_INIT + granted - sent_count) < 4) begin
            if (gap == 0) begin
                i_tx_credit = 1'b1;
                granted++;
                credit_rng = xorshift(credit_rng);
                gap = int'(credit_rng % 8);
            end else begin
                gap--;
            end
        end
    end

    always @(posedge i_clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("tests failed");
            $finish;
        end
    end

    // one host word, then 3 quiet cycles
    task automatic send_word(input word_t w);
        @(negedge i_clk);
        i_rx_valid = 1'b1;
        i_rx_data  = w;
        @(negedge i_clk);
        i_rx_valid = 1'b0;
        repeat (2) @(negedge i_clk);
    endtask

    task automatic wait_idle();
        while (o_busy)
            @(negedge i_clk);
    endtask

    task automatic queue_dump(input int retired);
        for (int i = 0; i < DUMP_WORDS; i++)
            exp_q.push_back(ref_dump_word(retired, i));
    endtask

    task automatic commit_run(input int retired);
        word_t next [NUM_REGS];
        for (int i = 0; i < NUM_REGS; i++)
            next[i] = ref_dump_word(retired, i);
        base_regs = next;
    endtask

    // send a command and wait for its whole dump
    task automatic run_dump(input word_t cmd, input int retired);
        int target;
        queue_dump(retired);
        target = sent_count + DUMP_WORDS;
        send_word(cmd);
        while (sent_count < target)
            @(negedge i_clk);
    endtask

    task automatic load_program(input int len);
        word_t ins;
        send_word(CMD_LOAD);
        for (int i = 0; i <= len; i++) begin
            if (i == len) begin
                ins = END_INSTR;
            end else begin
                prog_rng = xorshift(prog_rng);
                ins = prog_rng;
                ins[31:28] = prog_rng[17] ? OP_ADD : OP_ADDI;
            end
            mem_model[i] = ins; // old words past the end stay behind
            send_word(ins);
        end
        wait_idle();
    endtask

    initial begin
        int len;
        int held;
        int sent0;
        i_clk       = 1'b0;
        i_reset     = 1'b1;
        i_rx_valid  = 1'b0;
        i_rx_data   = '0;
        i_tx_credit = 1'b0;
        errors      = 0;
        checks      = 0;
        sent_count  = 0;
        granted     = 0;
        gap         = 0;
        cycles      = 0;
        credit_on   = 1'b1;
        prog_rng    = SEED;
        credit_rng  = ~SEED; // separate stream for the credit gaps
        for (int i = 0; i < NUM_REGS; i++)
            base_regs[i] = '0;
        repeat (10) @(negedge i_clk);
        i_reset = 1'b0;

        // run commands with no program loaded
        send_word(CMD_CONT);
        send_word(CMD_STEP);
        repeat (40) begin
            @(negedge i_clk);
            check_flag(o_busy, 1'b0, "busy before any load");
        end
        check_count(sent_count, 0, "words sent before any load");

        for (int p = 0; p < NUM_PROGS; p++) begin
            prog_rng = xorshift(prog_rng);
            // each program is shorter than the last so old words stay past its end marker
            len = MAX_LEN - 2 * p - int'(prog_rng % 2);
            load_program(len);

            // continuous run with credits held back at first
            credit_on = 1'b0;
            repeat (2) @(negedge i_clk);
            queue_dump(IMEM_DEPTH);
            sent0 = sent_count;
            send_word(CMD_CONT);
            repeat (60) @(negedge i_clk);
            held = CREDIT_INIT + granted;
            if (held > sent0 + DUMP_WORDS)
                held = sent0 + DUMP_WORDS;
            check_count(sent_count, held, "words sent with credits withheld");
            credit_on = 1'b1;
            while (sent_count < sent0 + DUMP_WORDS)
                @(negedge i_clk);
            wait_idle();
            check_flag(o_halted, 1'b1, "halted after continuous run");
            commit_run(IMEM_DEPTH);

            // step through, two steps past the end marker
            send_word(CMD_STEP);
            for (int k = 1; k <= len + 2; k++)
                run_dump(CMD_NEXT, k);
            send_word(CMD_CANCEL);
            wait_idle();
            commit_run(len + 2);

            // rerun from pc 0 on top of the stepped registers
            run_dump(CMD_CONT, IMEM_DEPTH);
            wait_idle();
            check_flag(o_halted, 1'b1, "halted after rerun");
            commit_run(IMEM_DEPTH);
        end

        repeat (20) @(negedge i_clk);
        check_count(exp_q.size(), 0, "dump words never received");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== tx_credit_fifo.sv ====
`timescale 1ns/1ns

module tx_credit_fifo (
    input  logic             i_clk,
    input  logic             i_reset,
    input  logic             i_push,
    input  debug_pkg::word_t i_push_data,
    output logic             o_full,
    input  logic             i_credit,
    output logic             o_tx_valid,
    output debug_pkg::word_t o_tx_data
);
    import debug_pkg::*;

    word_t buf_mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
    logic [$clog2(FIFO_DEPTH+1)-1:0] count; // occupancy
    logic [7:0] credits;                     // words the host will still accept

    logic do_push;
    logic do_send;

    assign o_full  = (count == FIFO_DEPTH);
    assign do_push = i_push && !o_full;
    assign do_send = (count != 0) && (credits != 0); // one word per cycle max

    always_ff @(posedge i_clk) begin
        if (do_push)
            buf_mem[wr_ptr] <= i_push_data;
        if (do_send)
            o_tx_data <= buf_mem[rd_ptr];
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credits    <= 8'(CREDIT_INIT);
            o_tx_valid <= 1'b0;
        end else begin
            o_tx_valid <= do_send;
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1; // depth is a power of two, wraps itself
            if (do_send)
                rd_ptr <= rd_ptr + 1'b1;
            count   <= count + do_push - do_send;
            credits <= credits + i_credit - do_send; // grant and send together cancel
        end
    end

endmodule
